/* src/cache_pkg.sv */
package cache_pkg;

    // AHB-Lite transfer type, encoded as on the bus
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // AHB-Lite burst type
    // only the low encodings are needed here
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011
    } hburst_e;

    // lookup / miss controller
    typedef enum logic [1:0] {
        C_IDLE      = 2'b00,
        C_LOOKUP    = 2'b01,
        C_FILL_REQ  = 2'b10,
        C_FILL_DONE = 2'b11
    } ctrl_state_e;

    // line geometry, tied to the four-beat wrapping burst
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS = 128;
    localparam int OFFSET_BITS = 2;

endpackage

/* src/ahb_transfer_decoder.sv */
module ahb_transfer_decoder #(
    parameter int CACHE_SIZE = 8192,
    localparam int LINES = CACHE_SIZE / (cache_pkg::LINE_BITS / 8),
    localparam int INDEX_BITS = $clog2(LINES),
    localparam int TAG_BITS = 32 - INDEX_BITS - cache_pkg::OFFSET_BITS - 2
) (
    input  logic                              downstream_intf,
    input  logic                              arst_n,
    input  logic [31:0]                       up_haddr,
    input  cache_pkg::htrans_e                up_htrans,
    input  logic                              up_hready,
    output logic                              req_valid,
    output logic [TAG_BITS-1:0]               req_tag,
    output logic [INDEX_BITS-1:0]             req_index,
    output logic [cache_pkg::OFFSET_BITS-1:0] req_offset
);
    import cache_pkg::*;

    // byte lane bits below the word offset are ignored
    localparam int BYTE_BITS = 2;
    localparam int OFF_LSB = BYTE_BITS;
    localparam int IDX_LSB = OFF_LSB + OFFSET_BITS;
    localparam int TAG_LSB = IDX_LSB + INDEX_BITS;

    logic accept;

    // SEQ is taken like NONSEQ, IDLE and BUSY are dropped
    assign accept = up_hready && ((up_htrans == NONSEQ) || (up_htrans == SEQ));

    always_ff @(posedge downstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    // fields stay put until the next accepted transfer,
    // the array relies on that while a miss is refilled
    always_ff @(posedge downstream_intf) begin
        if (accept) begin
            req_tag    <= up_haddr[31:TAG_LSB];
            req_index  <= up_haddr[TAG_LSB-1:IDX_LSB];
            req_offset <= up_haddr[IDX_LSB-1:OFF_LSB];
        end
    end

endmodule

/* src/cache_array.sv */
module cache_array #(
    parameter int CACHE_SIZE = 8192,
    localparam int LINES = CACHE_SIZE / (cache_pkg::LINE_BITS / 8),
    localparam int INDEX_BITS = $clog2(LINES),
    localparam int TAG_BITS = 32 - INDEX_BITS - cache_pkg::OFFSET_BITS - 2
) (
    input  logic                              downstream_intf,
    input  logic                              arst_n,
    input  logic                              req_valid,
    input  logic [TAG_BITS-1:0]               req_tag,
    input  logic [INDEX_BITS-1:0]             req_index,
    input  logic [cache_pkg::OFFSET_BITS-1:0] req_offset,
    output logic                              hit,
    output logic [cache_pkg::LINE_BITS-1:0]   hit_line,
    output logic [cache_pkg::OFFSET_BITS-1:0] hit_offset,
    output logic                              busy,
    output logic                              fill_req,
    output logic [31:0]                       fill_addr,
    input  logic                              fill_ack,
    input  logic [cache_pkg::LINE_BITS-1:0]   fill_line
);
    import cache_pkg::*;

    logic                 valid_q [LINES];
    logic [TAG_BITS-1:0]  tag_q [LINES];
    logic [LINE_BITS-1:0] data_q [LINES];

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic line_hit;
    logic lookup;
    logic miss;
    logic fill_write;

    assign line_hit = valid_q[req_index] && (tag_q[req_index] == req_tag);

    // fresh request, or the missed one re-presented right after the fill
    assign lookup = req_valid || (state_q == C_FILL_DONE);

    // with nothing to look up an idle array reports hit so hready stays high
    assign hit = lookup ? line_hit : (state_q == C_IDLE);

    assign miss       = (state_q == C_IDLE) && req_valid && !line_hit;
    assign fill_write = (state_q == C_FILL_REQ) && fill_ack;

    assign hit_line   = data_q[req_index];
    assign hit_offset = req_offset;
    assign busy       = (state_q == C_FILL_REQ) || (state_q == C_LOOKUP);
    assign fill_req   = (state_q == C_FILL_REQ);

    always_comb begin
        state_d = state_q;
        case (state_q)
            C_IDLE: begin
                // previous ack still up, wait in lookup
                if (miss) begin
                    state_d = fill_ack ? C_LOOKUP : C_FILL_REQ;
                end
            end
            C_LOOKUP: begin
                if (!fill_ack) begin
                    state_d = C_FILL_REQ;
                end
            end
            C_FILL_REQ: begin
                if (fill_ack) begin
                    state_d = C_FILL_DONE;
                end
            end
            C_FILL_DONE: state_d = C_IDLE;
            default:     state_d = C_IDLE;
        endcase
    end

    always_ff @(posedge downstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= C_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge downstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < LINES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill_write) begin
            valid_q[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge downstream_intf) begin
        if (miss) begin
            fill_addr <= {req_tag, req_index, req_offset, 2'b00};
        end
        if (fill_write) begin
            tag_q[req_index]  <= req_tag;
            data_q[req_index] <= fill_line;
        end
    end

endmodule

/* src/line_refill_engine.sv */
module line_refill_engine (
    input  logic                            downstream_intf,
    input  logic                            arst_n,
    input  logic                            fill_req,
    input  logic [31:0]                     fill_addr,
    output logic                            fill_ack,
    output logic [cache_pkg::LINE_BITS-1:0] fill_line,
    output logic [31:0]                     dn_haddr,
    output cache_pkg::htrans_e              dn_htrans,
    output cache_pkg::hburst_e              dn_hburst,
    input  logic                            dn_hready,
    input  logic [31:0]                     dn_hrdata
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE  = 2'b00,
        R_BURST = 2'b01,
        R_ACK   = 2'b10
    } refill_state_e;

    localparam logic [OFFSET_BITS-1:0] LAST_BEAT = OFFSET_BITS'(WORDS_PER_LINE - 1);
    localparam int OFF_LSB = 2;
    localparam int OFF_MSB = OFF_LSB + OFFSET_BITS - 1;

    refill_state_e state_q;

    logic                   addr_act;
    logic                   data_act;
    logic [OFFSET_BITS-1:0] addr_cnt;
    logic [OFFSET_BITS-1:0] data_cnt;
    logic [OFFSET_BITS-1:0] data_off;

    // an address phase is on the bus
    assign addr_act  = (dn_htrans == NONSEQ) || (dn_htrans == SEQ);
    assign dn_hburst = addr_act ? WRAP4 : SINGLE;
    assign fill_ack  = (state_q == R_ACK);

    always_ff @(posedge downstream_intf or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= R_IDLE;
            dn_htrans <= IDLE;
            dn_haddr  <= '0;
            addr_cnt  <= '0;
            data_cnt  <= '0;
            data_act  <= 1'b0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    // first beat is the missed word itself
                    if (fill_req) begin
                        dn_htrans <= NONSEQ;
                        dn_haddr  <= {fill_addr[31:OFF_LSB], 2'b00};
                        addr_cnt  <= '0;
                        data_cnt  <= '0;
                        state_q   <= R_BURST;
                    end
                end
                R_BURST: begin
                    // nothing moves while memory holds hready low
                    if (dn_hready) begin
                        if (addr_act) begin
                            if (addr_cnt == LAST_BEAT) begin
                                dn_htrans <= IDLE;
                            end else begin
                                dn_htrans <= SEQ;
                                // wrap inside the 16-byte line
                                dn_haddr[OFF_MSB:OFF_LSB] <= dn_haddr[OFF_MSB:OFF_LSB] + 1'b1;
                                addr_cnt <= addr_cnt + 1'b1;
                            end
                        end
                        data_act <= addr_act;
                        if (data_act) begin
                            data_cnt <= data_cnt + 1'b1;
                            if (data_cnt == LAST_BEAT) begin
                                state_q <= R_ACK;
                            end
                        end
                    end
                end
                R_ACK: begin
                    if (!fill_req) begin
                        state_q <= R_IDLE;
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    // each beat lands in the slot its own address points at
    always_ff @(posedge downstream_intf) begin
        if ((state_q == R_BURST) && dn_hready) begin
            if (addr_act) begin
                data_off <= dn_haddr[OFF_MSB:OFF_LSB];
            end
            if (data_act) begin
                fill_line[{data_off, 5'd0} +: 32] <= dn_hrdata;
            end
        end
    end

endmodule

/* src/word_select_return.sv */
module word_select_return (
    input  logic                              hit,
    input  logic                              busy,
    input  logic [cache_pkg::LINE_BITS-1:0]   hit_line,
    input  logic [cache_pkg::OFFSET_BITS-1:0] hit_offset,
    output logic                              up_hready,
    output logic [31:0]                       up_hrdata
);
    import cache_pkg::*;

    logic [31:0] words [WORDS_PER_LINE];

    // stall on a pending miss or for the whole refill
    assign up_hready = hit && !busy;

    always_comb begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            words[w] = hit_line[w*32 +: 32];
        end
    end

    assign up_hrdata = words[hit_offset];

endmodule

/* src/cache_top.sv */
module cache_top #(
    parameter int CACHE_SIZE = 8192
) (
    input  logic               downstream_intf,
    input  logic               arst_n,
    // upstream requester
    input  logic [31:0]        up_haddr,
    input  cache_pkg::htrans_e up_htrans,
    output logic               up_hready,
    output logic [31:0]        up_hrdata,
    // downstream memory
    output logic [31:0]        dn_haddr,
    output cache_pkg::htrans_e dn_htrans,
    output cache_pkg::hburst_e dn_hburst,
    input  logic               dn_hready,
    input  logic [31:0]        dn_hrdata
);
    import cache_pkg::*;

    localparam int LINES = CACHE_SIZE / (LINE_BITS / 8);
    localparam int INDEX_BITS = $clog2(LINES);
    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS - 2;

    // at least four lines, and a power of two
    if ((CACHE_SIZE < 64) || ((CACHE_SIZE & (CACHE_SIZE - 1)) != 0)) begin : g_bad_size
        $error("CACHE_SIZE must be a power of two of at least 64");
    end

    logic                   req_valid;
    logic [TAG_BITS-1:0]    req_tag;
    logic [INDEX_BITS-1:0]  req_index;
    logic [OFFSET_BITS-1:0] req_offset;

    logic                   hit;
    logic [LINE_BITS-1:0]   hit_line;
    logic [OFFSET_BITS-1:0] hit_offset;
    logic                   busy;

    logic                   fill_req;
    logic [31:0]            fill_addr;
    logic                   fill_ack;
    logic [LINE_BITS-1:0]   fill_line;

    ahb_transfer_decoder #(
        .CACHE_SIZE(CACHE_SIZE)
    ) u_decode (
        .downstream_intf(downstream_intf),
        .arst_n         (arst_n),
        .up_haddr       (up_haddr),
        .up_htrans      (up_htrans),
        .up_hready      (up_hready),
        .req_valid      (req_valid),
        .req_tag        (req_tag),
        .req_index      (req_index),
        .req_offset     (req_offset)
    );

    cache_array #(
        .CACHE_SIZE(CACHE_SIZE)
    ) u_array (
        .downstream_intf(downstream_intf),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_tag        (req_tag),
        .req_index      (req_index),
        .req_offset     (req_offset),
        .hit            (hit),
        .hit_line       (hit_line),
        .hit_offset     (hit_offset),
        .busy           (busy),
        .fill_req       (fill_req),
        .fill_addr      (fill_addr),
        .fill_ack       (fill_ack),
        .fill_line      (fill_line)
    );

    line_refill_engine u_refill (
        .downstream_intf(downstream_intf),
        .arst_n         (arst_n),
        .fill_req       (fill_req),
        .fill_addr      (fill_addr),
        .fill_ack       (fill_ack),
        .fill_line      (fill_line),
        .dn_haddr       (dn_haddr),
        .dn_htrans      (dn_htrans),
        .dn_hburst      (dn_hburst),
        .dn_hready      (dn_hready),
        .dn_hrdata      (dn_hrdata)
    );

    word_select_return u_result (
        .hit       (hit),
        .busy      (busy),
        .hit_line  (hit_line),
        .hit_offset(hit_offset),
        .up_hready (up_hready),
        .up_hrdata (up_hrdata)
    );

endmodule

/* test/cache_properties.sv */
module cache_properties (
    input logic               downstream_intf,
    input logic               arst_n,
    input logic               fill_req,
    input logic               fill_ack,
    input logic [31:0]        dn_haddr,
    input cache_pkg::htrans_e dn_htrans,
    input cache_pkg::hburst_e dn_hburst,
    input logic               dn_hready
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    // bus stays idle after reset until a fill is requested
    idle_after_reset: assert property (@(posedge downstream_intf) disable iff (!arst_n)
        (dn_htrans == IDLE) && !fill_req |=> (dn_htrans == IDLE))
        else $error("dn_htrans left IDLE without a fill request");

    // a burst opened by NONSEQ goes on as WRAP4 inside the same line
    wrap_on_nonseq: assert property (@(posedge downstream_intf) disable iff (!arst_n)
        (dn_htrans == NONSEQ) && dn_hready |=>
            (dn_htrans == SEQ) && (dn_hburst == WRAP4) &&
            (dn_haddr[31:4] == $past(dn_haddr[31:4])))
        else $error("NONSEQ beat not followed by a WRAP4 SEQ beat in the same line");

    ack_needs_req: assert property (@(posedge downstream_intf) disable iff (!arst_n)
        $rose(fill_ack) |-> fill_req)
        else $error("fill_ack rose without fill_req");

    no_req_during_ack: assert property (@(posedge downstream_intf) disable iff (!arst_n)
        $rose(fill_req) |-> !fill_ack)
        else $error("fill_req rose while fill_ack still high");

endmodule

bind line_refill_engine cache_properties u_props (
    .downstream_intf(downstream_intf),
    .arst_n         (arst_n),
    .fill_req       (fill_req),
    .fill_ack       (fill_ack),
    .dn_haddr       (dn_haddr),
    .dn_htrans      (dn_htrans),
    .dn_hburst      (dn_hburst),
    .dn_hready      (dn_hready)
);

/* test/cache_tb.sv */
module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int MAX_LINES = 64;
    localparam int COLS = 5;

    logic        downstream_intf;
    logic        arst_n;
    logic [31:0] up_haddr;
    htrans_e     up_htrans;
    logic        up_hready;
    logic [31:0] up_hrdata;
    logic [31:0] dn_haddr;
    htrans_e     dn_htrans;
    hburst_e     dn_hburst;
    logic        dn_hready;
    logic [31:0] dn_hrdata;

    // columns: id, address, data, cumulative bursts, control
    logic [31:0] golden [MAX_LINES*COLS];
    int          n_lines = 0;
    bit          golden_ready = 1'b0;
    int          cycle_count = 0;
    int          burst_count = 0;
    int          error_count = 0;
    int          prev_bursts = 0;
    logic [31:0] lfsr_state = 32'h8bcd_a0bb;

    cache_top #(
        .CACHE_SIZE(1024)
    ) u_dut (
        .downstream_intf(downstream_intf),
        .arst_n         (arst_n),
        .up_haddr       (up_haddr),
        .up_htrans      (up_htrans),
        .up_hready      (up_hready),
        .up_hrdata      (up_hrdata),
        .dn_haddr       (dn_haddr),
        .dn_htrans      (dn_htrans),
        .dn_hburst      (dn_hburst),
        .dn_hready      (dn_hready),
        .dn_hrdata      (dn_hrdata)
    );

    initial begin
        downstream_intf = 1'b0;
        forever #4 downstream_intf = ~downstream_intf;
    end

    always @(posedge downstream_intf) begin
        cycle_count <= cycle_count + 1;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic take_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] golden_field(input int line, input int col);
        return golden[line*COLS + col];
    endfunction

    task automatic check_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
            error_count++;
        end
    endtask

    // a line is a hit when its expected burst count did not move
    task automatic check_read(input int k, input logic [31:0] rdata, input int bursts,
                              input int latency);
        logic [31:0] addr;
        addr = golden_field(k, 1);
        check_value($sformatf("read data at %h", addr), rdata, golden_field(k, 2));
        check_value($sformatf("burst count after %h", addr), 32'(bursts), golden_field(k, 3));
        if (golden_field(k, 3) == 32'(prev_bursts)) begin
            check_value($sformatf("hit latency at %h", addr), 32'(latency), 32'd1);
        end
        prev_bursts = int'(golden_field(k, 3));
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge downstream_intf);
        #1;
        arst_n = 1'b1;
    endtask

    // pipelined AHB reads, next address rides along with the current data phase
    task automatic run_group(input int first, input int last);
        int          addr_line;
        int          cur;
        int          acc_cycle;
        int          bursts;
        logic        ready;
        logic [31:0] rdata;
        cur = -1;
        acc_cycle = 0;
        @(posedge downstream_intf);
        #1;
        addr_line = first;
        up_haddr  = golden_field(first, 1);
        up_htrans = NONSEQ;
        while ((addr_line >= 0) || (cur >= 0)) begin
            @(negedge downstream_intf);
            ready  = up_hready;
            rdata  = up_hrdata;
            bursts = burst_count;
            @(posedge downstream_intf);
            #1;
            if (ready) begin
                if (cur >= 0) begin
                    check_read(cur, rdata, bursts, cycle_count - acc_cycle);
                end
                cur = addr_line;
                acc_cycle = cycle_count;
                if ((addr_line >= 0) && (addr_line < last)) begin
                    addr_line = addr_line + 1;
                    up_haddr  = golden_field(addr_line, 1);
                    up_htrans = NONSEQ;
                end else begin
                    addr_line = -1;
                    up_htrans = IDLE;
                end
            end
        end
    endtask

    // downstream memory, word at aligned address a holds a ^ c3a5_0000
    initial begin
        logic        data_phase;
        logic [31:0] data_addr;
        htrans_e     seen_trans;
        logic [31:0] seen_addr;
        logic        seen_ready;
        data_phase = 1'b0;
        data_addr  = '0;
        dn_hready  = 1'b1;
        dn_hrdata  = '0;
        forever begin
            @(negedge downstream_intf);
            seen_trans = dn_htrans;
            seen_addr  = dn_haddr;
            seen_ready = dn_hready;
            @(posedge downstream_intf);
            #1;
            if (!arst_n) begin
                data_phase = 1'b0;
            end else if (seen_ready) begin
                data_phase = (seen_trans == NONSEQ) || (seen_trans == SEQ);
                data_addr  = seen_addr;
                if (seen_trans == NONSEQ) begin
                    burst_count++;
                end
            end
            dn_hrdata = data_phase ? ({data_addr[31:2], 2'b00} ^ 32'hc3a5_0000) : '0;
            // roughly one beat in four stalls
            dn_hready = data_phase ? !(take_bit() && take_bit()) : 1'b1;
        end
    end

    initial begin
        int limit;
        wait (golden_ready);
        limit = n_lines * 200 + RESET_CYCLES;
        repeat (limit) @(posedge downstream_intf);
        $display("timeout: the reads did not finish within %0d clock cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int first;
        int last;
        int errors_before;
        int pass_count;
        int fail_count;
        pass_count = 0;
        fail_count = 0;
        arst_n     = 1'b0;
        up_haddr   = '0;
        up_htrans  = IDLE;
        for (int i = 0; i < MAX_LINES*COLS; i++) begin
            golden[i] = '1;
        end
        $readmemh("test/cache_golden.txt", golden);
        while ((n_lines < MAX_LINES) && (golden_field(n_lines, 0) !== '1)) begin
            n_lines++;
        end
        golden_ready = 1'b1;
        if (n_lines == 0) begin
            $display("no reads found in test/cache_golden.txt");
            error_count++;
        end
        apply_reset();
        first = 0;
        while (first < n_lines) begin
            last = first;
            while ((last + 1 < n_lines) && (golden_field(last + 1, 0) == golden_field(first, 0))) begin
                last++;
            end
            if ((golden_field(first, 4) & 32'h1) != 0) begin
                apply_reset();
            end
            errors_before = error_count;
            run_group(first, last);
            if (error_count == errors_before) begin
                pass_count++;
                $display("test %0d ok, %0d reads", golden_field(first, 0), last - first + 1);
            end else begin
                fail_count++;
                $display("test %0d failed, %0d reads", golden_field(first, 0), last - first + 1);
            end
            first = last + 1;
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if ((error_count == 0) && (fail_count == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* test/cache_golden.txt */
// id  address  data     bursts ctrl   all hex, one upstream read per row
// rows sharing an id run back to back; ctrl bit 0 resets the cache first
01 00000100 c3a50100 01 0
02 00000104 c3a50104 01 0
02 00000108 c3a50108 01 0
02 0000010c c3a5010c 01 0
02 00000100 c3a50100 01 0
03 00000500 c3a50500 02 0
03 00000100 c3a50100 03 0
04 00002a3c c3a52a3c 04 0
04 00002a30 c3a52a30 04 0
04 00002a34 c3a52a34 04 0
04 00002a38 c3a52a38 04 0
04 00010f74 c3a40f74 05 0
04 00010f70 c3a40f70 05 0
05 00000300 c3a50300 06 0
05 00000304 c3a50304 06 0
05 00000710 c3a50710 07 0
05 00000108 c3a50108 07 0
05 00002a38 c3a52a38 07 0
05 00000b0c c3a50b0c 08 0
05 00000300 c3a50300 09 0
06 00000100 c3a50100 0a 1
06 00002a3c c3a52a3c 0b 0
06 00010f70 c3a40f70 0c 0
06 00000104 c3a50104 0c 0

/* files.f */
src/cache_pkg.sv
src/ahb_transfer_decoder.sv
src/cache_array.sv
src/line_refill_engine.sv
src/word_select_return.sv
src/cache_top.sv
test/cache_properties.sv
test/cache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module cache_tb -o cache_sim

# the run only counts if the pass line shows up in the output
./obj_dir/cache_sim | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null
echo "simulation passed"
